// ==== source/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    typedef logic [31:0]  addr_t;
    typedef logic [31:0]  word_t;
    typedef logic [63:0]  beat_t;
    typedef logic [255:0] line_t;
    typedef logic [63:0]  order_t;

    // line geometry is fixed by the types above
    localparam int BEATS_PER_LINE = 4;
    localparam int WORDS_PER_LINE = 8;

    // byte address without the 5 offset bits
    typedef logic [26:0] line_tag_t;

    typedef struct packed {
        addr_t pc;
        word_t inst;
    } queue_entry_t;

    // toward decode
    typedef struct packed {
        logic   valid;
        order_t order;
        addr_t  pc;
        word_t  inst;
    } fetch_packet_t;

    typedef struct packed {
        logic  valid;
        addr_t target;
    } redirect_t;

    typedef struct packed {
        logic      valid;
        line_tag_t tag;
    } line_req_t;

    typedef struct packed {
        logic      valid;
        line_tag_t tag;
        line_t     data;
    } line_resp_t;

    typedef enum logic [1:0] {
        reader_idle,
        reader_request,
        reader_collect
    } reader_state_e;

endpackage

`default_nettype wire

// ==== source/burst_line_reader.sv ====
`default_nettype none

module burst_line_reader (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire fetch_pkg::line_req_t   line_req_i,
    output fetch_pkg::line_resp_t       line_resp_o,
    output fetch_pkg::addr_t            bmem_addr_o,
    output logic                        bmem_read_o,
    input  wire logic                   bmem_ready_i,
    input  wire fetch_pkg::addr_t       bmem_raddr_i,
    input  wire fetch_pkg::beat_t       bmem_rdata_i,
    input  wire logic                   bmem_rvalid_i
);
    import fetch_pkg::*;

    localparam int BEAT_W = $bits(beat_t);
    localparam int IDX_W  = $clog2(BEATS_PER_LINE);

    reader_state_e      state;
    line_tag_t          tag_q;
    line_t              line_q;
    logic [IDX_W-1:0]   beat_idx;
    logic               resp_valid;
    logic               beat_ok;

    // only beats for the latched line count
    assign beat_ok = bmem_rvalid_i && (bmem_raddr_i[31:5] == tag_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= reader_idle;
            beat_idx   <= '0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                reader_idle: begin
                    if (line_req_i.valid) begin
                        state <= reader_request;
                    end
                end
                reader_request: begin
                    if (bmem_ready_i) begin
                        state    <= reader_collect;
                        beat_idx <= '0;
                    end
                end
                reader_collect: begin
                    if (beat_ok) begin
                        beat_idx <= beat_idx + 1'b1;
                        if (beat_idx == IDX_W'(BEATS_PER_LINE - 1)) begin
                            state      <= reader_idle;
                            resp_valid <= 1'b1;
                        end
                    end
                end
                default: state <= reader_idle;
            endcase
        end
    end

    // latched tag and assembled line
    always_ff @(posedge clk) begin
        if (state == reader_idle && line_req_i.valid) begin
            tag_q <= line_req_i.tag;
        end
        if (state == reader_collect && beat_ok) begin
            line_q[beat_idx*BEAT_W +: BEAT_W] <= bmem_rdata_i;
        end
    end

    assign bmem_read_o = (state == reader_request);
    assign bmem_addr_o = {tag_q, 5'b0};

    assign line_resp_o.valid = resp_valid;
    assign line_resp_o.tag   = tag_q;
    assign line_resp_o.data  = line_q;

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
`default_nettype none

module fetch_unit #(
    parameter fetch_pkg::addr_t RESET_PC = 32'haaaaa000
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire fetch_pkg::redirect_t       redirect_i,
    output fetch_pkg::line_req_t            line_req_o,
    input  wire fetch_pkg::line_resp_t      line_resp_i,
    output logic                            enq_valid_o,
    output fetch_pkg::queue_entry_t         enq_entry_o,
    input  wire logic                       full_i
);
    import fetch_pkg::*;

    localparam int WORD_W = $bits(word_t);
    localparam int WIDX_W = $clog2(WORDS_PER_LINE);

    addr_t              pc;
    logic               buf_valid;
    line_tag_t          buf_tag;
    line_t              buf_line;

    logic               req_valid_q;
    line_tag_t          req_tag_q;
    logic               req_pending;

    logic               hit;
    logic [WIDX_W-1:0]  word_idx;
    word_t              word;
    logic               enq_fire;

    assign hit      = buf_valid && (buf_tag == pc[31:5]);
    assign word_idx = pc[4:2];
    assign word     = buf_line[word_idx*WORD_W +: WORD_W];

    // a redirect kills the write of its own cycle
    assign enq_valid_o       = hit && !redirect_i.valid;
    assign enq_entry_o.pc    = pc;
    assign enq_entry_o.inst  = word;
    assign enq_fire          = enq_valid_o && !full_i;

    // program counter
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (redirect_i.valid) begin
            pc <= redirect_i.target;
        end else if (enq_fire) begin
            pc <= pc + 32'd4;
        end
    end

    // one miss request pulse per outstanding line
    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid_q <= 1'b0;
            req_pending <= 1'b0;
        end else begin
            req_valid_q <= 1'b0;
            if (line_resp_i.valid) begin
                req_pending <= 1'b0;
            end else if (!hit && !req_pending && !redirect_i.valid) begin
                req_valid_q <= 1'b1;
                req_pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!hit && !req_pending && !redirect_i.valid) begin
            req_tag_q <= pc[31:5];
        end
    end

    assign line_req_o.valid = req_valid_q;
    assign line_req_o.tag   = req_tag_q;

    // line buffer takes every response
    // the pc may have moved on so hit is checked again next cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            buf_valid <= 1'b0;
        end else if (line_resp_i.valid) begin
            buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (line_resp_i.valid) begin
            buf_tag  <= line_resp_i.tag;
            buf_line <= line_resp_i.data;
        end
    end

endmodule

`default_nettype wire

// ==== source/inst_queue.sv ====
`default_nettype none

module inst_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       flush_i,
    input  wire logic                       enq_valid_i,
    input  wire fetch_pkg::queue_entry_t    enq_entry_i,
    output logic                            full_o,
    input  wire logic                       deq_i,
    output logic                            empty_o,
    output fetch_pkg::queue_entry_t         head_o
);
    import fetch_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    queue_entry_t       mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   wr_ptr;
    logic [CNT_W-1:0]   count;
    logic               do_wr;
    logic               do_rd;

    assign full_o  = (count == CNT_W'(QUEUE_DEPTH));
    assign empty_o = (count == '0);
    assign head_o  = mem[rd_ptr];

    assign do_wr = enq_valid_i && !full_o && !flush_i;
    assign do_rd = deq_i && !empty_o && !flush_i;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_wr) - CNT_W'(do_rd);
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= enq_entry_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/issue_credit_port.sv ====
`default_nettype none

module issue_credit_port #(
    parameter int FETCH_CREDITS = 4
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       empty_i,
    input  wire fetch_pkg::queue_entry_t    head_i,
    output logic                            deq_o,
    input  wire logic                       credit_return_i,
    output fetch_pkg::fetch_packet_t        fetch_o
);
    import fetch_pkg::*;

    localparam int CW = $clog2(FETCH_CREDITS + 1);

    logic [CW-1:0]  credits;
    logic [CW-1:0]  credits_next;
    order_t         order_q;
    logic           deliver;

    // head goes out in the same cycle a credit is free
    assign deliver = !empty_i && (credits != '0);
    assign deq_o   = deliver;

    assign fetch_o.valid = deliver;
    assign fetch_o.order = order_q;
    assign fetch_o.pc    = head_i.pc;
    assign fetch_o.inst  = head_i.inst;

    always_comb begin
        credits_next = credits;
        if (deliver) begin
            credits_next = credits_next - 1'b1;
        end
        if (credit_return_i) begin
            credits_next = credits_next + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CW'(FETCH_CREDITS);
            order_q <= '0;
        end else begin
            credits <= credits_next;
            if (deliver) begin
                order_q <= order_q + 64'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/fetch_top.sv ====
`default_nettype none

module fetch_top #(
    parameter fetch_pkg::addr_t RESET_PC      = 32'haaaaa000,
    parameter int               QUEUE_DEPTH   = 8,
    parameter int               FETCH_CREDITS = 4
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    output fetch_pkg::addr_t                bmem_addr_o,
    output logic                            bmem_read_o,
    input  wire logic                       bmem_ready_i,
    input  wire fetch_pkg::addr_t           bmem_raddr_i,
    input  wire fetch_pkg::beat_t           bmem_rdata_i,
    input  wire logic                       bmem_rvalid_i,
    input  wire fetch_pkg::redirect_t       redirect_i,
    output fetch_pkg::fetch_packet_t        fetch_o,
    input  wire logic                       credit_return_i
);
    import fetch_pkg::*;

    line_req_t      line_req;
    line_resp_t     line_resp;
    logic           enq_valid;
    queue_entry_t   enq_entry;
    logic           full;
    logic           deq;
    logic           empty;
    queue_entry_t   head;

    burst_line_reader i_reader (
        .clk            (clk),
        .rst            (rst),
        .line_req_i     (line_req),
        .line_resp_o    (line_resp),
        .bmem_addr_o    (bmem_addr_o),
        .bmem_read_o    (bmem_read_o),
        .bmem_ready_i   (bmem_ready_i),
        .bmem_raddr_i   (bmem_raddr_i),
        .bmem_rdata_i   (bmem_rdata_i),
        .bmem_rvalid_i  (bmem_rvalid_i)
    );

    fetch_unit #(
        .RESET_PC       (RESET_PC)
    ) i_fetch (
        .clk            (clk),
        .rst            (rst),
        .redirect_i     (redirect_i),
        .line_req_o     (line_req),
        .line_resp_i    (line_resp),
        .enq_valid_o    (enq_valid),
        .enq_entry_o    (enq_entry),
        .full_i         (full)
    );

    // redirect empties the queue in one cycle
    inst_queue #(
        .QUEUE_DEPTH    (QUEUE_DEPTH)
    ) i_queue (
        .clk            (clk),
        .rst            (rst),
        .flush_i        (redirect_i.valid),
        .enq_valid_i    (enq_valid),
        .enq_entry_i    (enq_entry),
        .full_o         (full),
        .deq_i          (deq),
        .empty_o        (empty),
        .head_o         (head)
    );

    issue_credit_port #(
        .FETCH_CREDITS  (FETCH_CREDITS)
    ) i_issue (
        .clk            (clk),
        .rst            (rst),
        .empty_i        (empty),
        .head_i         (head),
        .deq_o          (deq),
        .credit_return_i(credit_return_i),
        .fetch_o        (fetch_o)
    );

endmodule

`default_nettype wire

// ==== dv/fetch_sva.sv ====
`default_nettype none

module fetch_sva #(
    parameter int FETCH_CREDITS = 4
) (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic [31:0]    credits_i,
    input  wire logic           fetch_valid_i,
    input  wire logic           credit_return_i,
    input  wire logic           bmem_read_i,
    input  wire logic           bmem_ready_i,
    input  wire logic           bmem_rvalid_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;

    int credits_seen;
    int beats_left;

    // credits as seen from the consumer handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            credits_seen <= FETCH_CREDITS;
        end else begin
            credits_seen <= credits_seen + int'(credit_return_i) - int'(fetch_valid_i);
        end
    end

    // beats still owed by memory after an accepted read
    always_ff @(posedge clk) begin
        if (rst) begin
            beats_left <= 0;
        end else if (bmem_read_i && bmem_ready_i) begin
            beats_left <= BEATS_PER_LINE;
        end else if (bmem_rvalid_i && beats_left > 0) begin
            beats_left <= beats_left - 1;
        end
    end

    credit_bound: assert property (@(posedge clk) disable iff (rst)
        credits_i <= 32'(FETCH_CREDITS))
        else $error("credit count above its limit");

    // a delivery needs a free credit
    valid_needs_credit: assert property (@(posedge clk) disable iff (rst)
        fetch_valid_i |-> credits_seen != 0)
        else $error("fetch valid with zero credits");

    no_read_in_collect: assert property (@(posedge clk) disable iff (rst)
        beats_left != 0 |-> !bmem_read_i)
        else $error("memory read raised while beats are collected");

endmodule

bind issue_credit_port fetch_sva #(.FETCH_CREDITS(FETCH_CREDITS)) i_credit_sva (
    .clk            (clk),
    .rst            (rst),
    .credits_i      (32'(credits)),
    .fetch_valid_i  (fetch_o.valid),
    .credit_return_i(credit_return_i),
    .bmem_read_i    (1'b0),
    .bmem_ready_i   (1'b0),
    .bmem_rvalid_i  (1'b0)
);

bind burst_line_reader fetch_sva i_reader_sva (
    .clk            (clk),
    .rst            (rst),
    .credits_i      (32'd0),
    .fetch_valid_i  (1'b0),
    .credit_return_i(1'b0),
    .bmem_read_i    (bmem_read_o),
    .bmem_ready_i   (bmem_ready_i),
    .bmem_rvalid_i  (bmem_rvalid_i)
);

`default_nettype wire

// ==== dv/tb_fetch_mem.sv ====
`default_nettype none

module tb_fetch_mem (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               random_latency_i,
    input  wire fetch_pkg::addr_t   bmem_addr_i,
    input  wire logic               bmem_read_i,
    output logic                    bmem_ready_o,
    output fetch_pkg::addr_t        bmem_raddr_o,
    output fetch_pkg::beat_t        bmem_rdata_o,
    output logic                    bmem_rvalid_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;

    logic [31:0]    lfsr = 32'he37a;
    logic           busy;
    addr_t          line_addr;
    addr_t          beat_addr;
    int             beat_idx;
    int             gap;
    int             wait_cnt;

    // rotate left by 7 then xor with a fixed mask
    function automatic word_t word_at(input addr_t a);
        return {a[24:0], a[31:25]} ^ 32'h5a5a0f0f;
    endfunction

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic int pick_delay(input int nbits);
        if (!random_latency_i) begin
            return 0;
        end
        return int'(take_bits(nbits));
    endfunction

    initial begin
        bmem_ready_o  = 1'b0;
        bmem_raddr_o  = '0;
        bmem_rdata_o  = '0;
        bmem_rvalid_o = 1'b0;
        busy          = 1'b0;
        line_addr     = '0;
        beat_addr     = '0;
        beat_idx      = 0;
        gap           = 0;
        wait_cnt      = 0;
        forever begin
            @(negedge clk);
            bmem_ready_o  = 1'b0;
            bmem_rvalid_o = 1'b0;
            if (rst) begin
                busy     = 1'b0;
                wait_cnt = 0;
            end else if (busy) begin
                // beats go out lowest address first with optional gaps
                if (gap > 0) begin
                    gap = gap - 1;
                end else begin
                    beat_addr     = line_addr + 32'(beat_idx * 8);
                    bmem_rvalid_o = 1'b1;
                    bmem_raddr_o  = line_addr;
                    bmem_rdata_o  = {word_at(beat_addr + 32'd4), word_at(beat_addr)};
                    beat_idx      = beat_idx + 1;
                    if (beat_idx == BEATS_PER_LINE) begin
                        busy = 1'b0;
                    end
                    gap = pick_delay(2);
                end
            end else if (bmem_read_i) begin
                if (wait_cnt > 0) begin
                    wait_cnt = wait_cnt - 1;
                end else begin
                    // ready here means accept on the next rising edge
                    bmem_ready_o = 1'b1;
                    line_addr    = bmem_addr_i;
                    busy         = 1'b1;
                    beat_idx     = 0;
                    gap          = pick_delay(2);
                    wait_cnt     = pick_delay(3);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_fetch.sv ====
`default_nettype none

module tb_fetch;
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;

    localparam addr_t RESET_PC      = 32'haaaaa000;
    localparam int    QUEUE_DEPTH   = 8;
    localparam int    FETCH_CREDITS = 4;
    localparam int    RESET_CYCLES  = 8;

    // deliveries per test
    localparam int SEQ_COUNT      = 24;
    localparam int REUSE_COUNT    = 16;
    localparam int RESUME_COUNT   = 12;
    localparam int REDIRECT_COUNT = 10;
    localparam int STRESS_COUNT   = 300;
    localparam int HOLD_CYCLES    = 100;
    // accept delay, four beats with gaps, plus a line thrown away by a redirect
    localparam int LINE_COST      = 64;
    localparam int TOTAL_INSTS    = SEQ_COUNT + REUSE_COUNT + FETCH_CREDITS
                                  + RESUME_COUNT + REDIRECT_COUNT + STRESS_COUNT;
    localparam int WATCHDOG_NS    = 10 * (RESET_CYCLES + HOLD_CYCLES + TOTAL_INSTS * LINE_COST);

    localparam int RETURN_ALL    = 0;
    localparam int RETURN_NONE   = 1;
    localparam int RETURN_RANDOM = 2;

    logic           clk;
    logic           rst;
    addr_t          bmem_addr;
    logic           bmem_read;
    logic           bmem_ready;
    addr_t          bmem_raddr;
    beat_t          bmem_rdata;
    logic           bmem_rvalid;
    redirect_t      redirect;
    fetch_packet_t  fetch;
    logic           credit_return;
    logic           random_latency;

    // consumer side model
    addr_t          exp_pc;
    order_t         exp_order;
    int             held;
    int             n_deliv;
    int             redir_done;
    int             packet_errors;
    logic [31:0]    lfsr = 32'he37a;

    // test control from the main sequence
    int             credit_mode;
    logic           random_redirects;
    int             redir_seq;
    addr_t          redir_target;
    int             count_errors;

    addr_t          accepted [$];

    fetch_top #(
        .RESET_PC       (RESET_PC),
        .QUEUE_DEPTH    (QUEUE_DEPTH),
        .FETCH_CREDITS  (FETCH_CREDITS)
    ) i_dut (
        .clk            (clk),
        .rst            (rst),
        .bmem_addr_o    (bmem_addr),
        .bmem_read_o    (bmem_read),
        .bmem_ready_i   (bmem_ready),
        .bmem_raddr_i   (bmem_raddr),
        .bmem_rdata_i   (bmem_rdata),
        .bmem_rvalid_i  (bmem_rvalid),
        .redirect_i     (redirect),
        .fetch_o        (fetch),
        .credit_return_i(credit_return)
    );

    tb_fetch_mem i_mem (
        .clk             (clk),
        .rst             (rst),
        .random_latency_i(random_latency),
        .bmem_addr_i     (bmem_addr),
        .bmem_read_i     (bmem_read),
        .bmem_ready_o    (bmem_ready),
        .bmem_raddr_o    (bmem_raddr),
        .bmem_rdata_o    (bmem_rdata),
        .bmem_rvalid_o   (bmem_rvalid)
    );

    function automatic word_t expected_inst(input addr_t a);
        return {a[24:0], a[31:25]} ^ 32'h5a5a0f0f;
    endfunction

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic int reads_in_window(input addr_t base, input addr_t bytes);
        int n;
        n = 0;
        foreach (accepted[i]) begin
            if (accepted[i] >= base && accepted[i] < base + bytes) begin
                n = n + 1;
            end
        end
        return n;
    endfunction

    task automatic compare_packet(input fetch_packet_t actual, input fetch_packet_t expected);
        if (actual !== expected) begin
            packet_errors = packet_errors + 1;
            $display("[FAIL] %0t: got order %0d pc %h inst %h, expected order %0d pc %h inst %h",
                     $time, actual.order, actual.pc, actual.inst,
                     expected.order, expected.pc, expected.inst);
        end
    endtask

    task automatic compare_count(input int actual, input int expected, input string what);
        if (actual != expected) begin
            count_errors = count_errors + 1;
            $display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    // one consumer cycle checks the delivery then drives credit and redirect
    task automatic serve_cycle();
        fetch_packet_t expected;
        logic [31:0]   bits;
        logic          give_back;
        give_back = 1'b0;
        if (fetch.valid) begin
            expected.valid = 1'b1;
            expected.order = exp_order;
            expected.pc    = exp_pc;
            expected.inst  = expected_inst(exp_pc);
            compare_packet(fetch, expected);
            exp_pc    = exp_pc + 32'd4;
            exp_order = exp_order + 64'd1;
            held      = held + 1;
            n_deliv   = n_deliv + 1;
        end
        if (held > 0) begin
            case (credit_mode)
                RETURN_ALL:    give_back = 1'b1;
                RETURN_RANDOM: give_back = (take_bits(1) != 32'd0);
                default:       give_back = 1'b0;
            endcase
        end
        if (give_back) begin
            held = held - 1;
        end
        credit_return = give_back;
        redirect      = '0;
        if (redir_done != redir_seq) begin
            redirect.valid  = 1'b1;
            redirect.target = redir_target;
            exp_pc          = redir_target;
            redir_done      = redir_seq;
        end else if (random_redirects) begin
            bits = take_bits(7);
            if (bits == 32'd0) begin
                bits            = take_bits(12);
                redirect.valid  = 1'b1;
                redirect.target = {RESET_PC[31:14], bits[11:0], 2'b00};
                exp_pc          = redirect.target;
            end
        end
    endtask

    task automatic wait_deliveries(input int n);
        int target;
        target = n_deliv + n;
        while (n_deliv < target) begin
            @(posedge clk);
        end
    endtask

    task automatic request_redirect(input addr_t target);
        @(posedge clk);
        redir_target = target;
        redir_seq    = redir_seq + 1;
        while (redir_done != redir_seq) begin
            @(posedge clk);
        end
    endtask

    task automatic stream_from_reset();
        @(posedge clk);
        credit_mode = RETURN_ALL;
        wait_deliveries(SEQ_COUNT);
    endtask

    task automatic reuse_one_line();
        addr_t base;
        base = RESET_PC + 32'h800;
        request_redirect(base);
        wait_deliveries(REUSE_COUNT);
        compare_count(reads_in_window(base, 32'd64), 2, "line reads for 16 instructions");
    endtask

    task automatic stall_on_credits();
        int start;
        @(posedge clk);
        credit_mode = RETURN_NONE;
        start       = n_deliv;
        repeat (HOLD_CYCLES) @(posedge clk);
        compare_count(n_deliv - start, FETCH_CREDITS, "deliveries without credit return");
        credit_mode = RETURN_ALL;
        wait_deliveries(RESUME_COUNT);
    endtask

    task automatic jump_to_target();
        request_redirect(RESET_PC + 32'h2014);
        wait_deliveries(REDIRECT_COUNT);
    endtask

    task automatic stress_random();
        @(posedge clk);
        random_latency   = 1'b1;
        credit_mode      = RETURN_RANDOM;
        random_redirects = 1'b1;
        wait_deliveries(STRESS_COUNT);
        random_redirects = 1'b0;
        credit_mode      = RETURN_ALL;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset and consumer drive the DUT on the falling edge
    initial begin
        rst           = 1'b1;
        redirect      = '0;
        credit_return = 1'b0;
        exp_pc        = RESET_PC;
        exp_order     = '0;
        held          = 0;
        n_deliv       = 0;
        redir_done    = 0;
        packet_errors = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        forever begin
            @(negedge clk);
            serve_cycle();
        end
    end

    always @(posedge clk) begin
        if (!rst && bmem_read && bmem_ready) begin
            accepted.push_back(bmem_addr);
        end
    end

    initial begin
        credit_mode      = RETURN_ALL;
        random_redirects = 1'b0;
        random_latency   = 1'b0;
        redir_seq        = 0;
        redir_target     = '0;
        count_errors     = 0;
        @(negedge rst);
        stream_from_reset();
        reuse_one_line();
        stall_on_credits();
        jump_to_target();
        stress_random();
        @(posedge clk);
        $display("errors: %0d delivery, %0d count", packet_errors, count_errors);
        if (packet_errors == 0 && count_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: tests did not finish within %0d ns, the fetch stream stalled",
                 WATCHDOG_NS);
        $display("errors: %0d delivery, %0d count", packet_errors, count_errors);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
source/fetch_pkg.sv
source/burst_line_reader.sv
source/fetch_unit.sv
source/inst_queue.sv
source/issue_credit_port.sv
source/fetch_top.sv
dv/fetch_sva.sv
dv/tb_fetch_mem.sv
dv/tb_fetch.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps -j 0 \
    --top-module tb_fetch -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_fetch)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1
